/* project.f */
source/pong_pkg.sv
source/video_timing.sv
source/move_timer.sv
source/rally_fsm.sv
source/ball_position.sv
source/score_keeper.sv
source/pixel_mixer.sv
source/pong_top.sv
test/pong_assert.sv
test/pong_tb.sv

/* test/pong_tb.sv */
`timescale 1ns/10ps

module pong_tb
    import pong_pkg::*;
;

    localparam int   drive_delay   = 1;             // ns after the rising edge
    localparam int   frame_limit   = 500000;        // One frame plus margin
    localparam int   ball_limit    = 2000000;
    localparam rgb_t white_px      = '{r: 8'hFF, g: 8'hFF, b: 8'hFF};

    typedef enum {cls_black, cls_white, cls_dim} colour_e;

    logic        iCLK = 1'b0;
    logic        iRST_N;
    rgb_t        pixel_in;
    logic        request;
    rgb_t        pixel_out;
    vga_sync_t   sync;
    screen_pos_t pos;
    score_t      score;

    // Reference model state, updated on the rising edge
    int          mh;
    int          mv;
    int          mx;
    int          my;
    bit          mright;
    bit          mdown;
    int          msl;
    int          msr;
    int          mphase;

    logic [15:0] lfsr;
    string       row_name[$];
    int          row_h[$];                          // Absolute h, or x offset for ball rows
    int          row_v[$];
    bit          row_rel[$];                        // Row tracks the ball
    colour_e     row_cls[$];

    pong_top #(.move_tick_bits(2)) dut (
        .iCLK      (iCLK),
        .iRST_N    (iRST_N),
        .pixel_in  (pixel_in),
        .request   (request),
        .pixel_out (pixel_out),
        .sync      (sync),
        .pos       (pos),
        .score     (score)
    );

    always #50 iCLK = ~iCLK;                        // 100 ns period

    // ========================================================================
    // Reference model of raster, ball and scores
    // ========================================================================
    always @(posedge iCLK) begin
        if (!iRST_N) begin
            mh     = 0;
            mv     = 0;
            mx     = 320;
            my     = 240;
            mright = 1'b1;                          // Serve down and right
            mdown  = 1'b1;
            msl    = 0;
            msr    = 0;
            mphase = 0;
        end else begin
            if (mh == 0)
                mv = (mv == 524) ? 0 : mv + 1;
            mh = (mh == 799) ? 0 : mh + 1;
            if (mphase == 0) begin                  // Move tick every fourth cycle
                if (mright && (mx + 10 >= 790)) begin
                    mright = 1'b0;
                    if (msl < 10)
                        msl++;
                end else if (!mright && (mx <= 150)) begin
                    mright = 1'b1;
                    if (msr < 10)
                        msr++;
                end else begin
                    mx = mright ? mx + 1 : mx - 1;
                end
                if (mdown && (my + 10 >= 525))
                    mdown = 1'b0;
                else if (!mdown && (my <= 50))
                    mdown = 1'b1;
                else
                    my = mdown ? my + 1 : my - 1;
            end
            mphase = (mphase + 1) % 4;
        end
    end

    function automatic vga_sync_t expected_sync(input int h, input int v);
        vga_sync_t s;
        s.h_sync  = !((h >= 7) && (h <= 102));
        s.v_sync  = !((v >= 11) && (v <= 12));
        s.visible = (h >= 160) && (v >= 45);
        return s;
    endfunction

    function automatic logic expected_request(input int h, input int v);
        return (h >= 161) && (h <= 800) && (v >= 44) && (v <= 523);
    endfunction

    // Paddles and centre dash, ignoring the ball
    function automatic bit static_white(input int h, input int v);
        bit rows;
        rows = (v >= 244) && (v <= 323);
        if (rows && (((h >= 195) && (h <= 214)) || ((h >= 744) && (h <= 763))))
            return 1'b1;
        return (h == 465) && (((v >> 5) & 1) == 0);
    endfunction

    function automatic bit in_model_ball(input int h, input int v);
        return (h >= mx) && (h <= mx + 9) && (v >= my) && (v <= my + 9);
    endfunction

    function automatic rgb_t half_colour(input rgb_t p);
        return '{r: p.r >> 1, g: p.g >> 1, b: p.b >> 1};
    endfunction

    // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic draw_colour(output rgb_t c);
        logic [23:0] bits;
        bits = '0;
        for (int i = 0; i < 24; i++) begin
            bits = {bits[22:0], lfsr[0]};           // One step per bit
            lfsr = lfsr_next(lfsr);
        end
        c = bits;
    endtask

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_sync(input string name, input vga_sync_t exp, input vga_sync_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_pos(input string name, input screen_pos_t exp,
                             input screen_pos_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %0d/%0d, actual %0d/%0d",
                     name, exp.h, exp.v, act.h, act.v);
            stop_on_error();
        end
    endtask

    task automatic check_score(input string name, input score_t exp, input score_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %0d/%0d, actual %0d/%0d",
                     name, exp.left, exp.right, act.left, act.right);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    // Counters, decode and scores on every cycle, sampled mid-period
    always @(negedge iCLK) begin
        if (iRST_N === 1'b1) begin
            check_pos("raster", '{h: 11'(mh), v: 10'(mv)}, pos);
            check_sync("sync", expected_sync(mh, mv), sync);
            check_bit("request", expected_request(mh, mv), request);
            check_score("score", '{left: 4'(msl), right: 4'(msr)}, score);
        end
    end

    // ========================================================================
    // Stimulus table and its loop
    // ========================================================================
    task automatic add_row(input string name, input int h, input int v,
                           input bit rel, input colour_e cls);
        row_name.push_back(name);
        row_h.push_back(h);
        row_v.push_back(v);
        row_rel.push_back(rel);
        row_cls.push_back(cls);
    endtask

    // Ball rows match on any ball line at the given x offset
    function automatic bit ball_target(input int dx);
        return (mh == mx + dx) && (mv >= my) && (mv <= my + 9) &&
               (mh >= 160) && (mv >= 45) && !static_white(mh, mv);
    endfunction

    task automatic wait_target(input int idx);
        int n = 0;
        bit hit = 1'b0;
        while (!hit) begin
            @(posedge iCLK);
            #drive_delay;
            if (row_rel[idx])
                hit = ball_target(row_h[idx]);
            else
                hit = (mh == row_h[idx]) && (mv == row_v[idx]);
            n++;
            if (!hit && (n > (row_rel[idx] ? ball_limit : frame_limit))) begin
                $display("Timed out waiting for the target of row %s", row_name[idx]);
                stop_on_error();
            end
        end
    endtask

    task automatic run_row(input int idx);
        rgb_t pin;
        rgb_t exp;
        wait_target(idx);
        draw_colour(pin);
        pixel_in = pin;
        case (row_cls[idx])
            cls_black: exp = '0;
            cls_white: exp = white_px;
            default:   exp = in_model_ball(mh, mv) ? white_px : half_colour(pin);
        endcase
        @(negedge iCLK);
        check_rgb(row_name[idx], exp, pixel_out);
    endtask

    initial begin
        int n;
        iRST_N   = 1'b0;
        pixel_in = '0;
        lfsr     = 16'd30901;
        // Absolute rows in raster order, so one frame covers them
        add_row("top_blank",       300,  20, 1'b0, cls_black);
        add_row("dash_on",         465,  70, 1'b0, cls_white);
        add_row("left_blank",      100, 100, 1'b0, cls_black);
        add_row("dash_off",        465, 100, 1'b0, cls_dim);
        add_row("lpad_corner",     195, 244, 1'b0, cls_white);
        add_row("rpad_corner",     744, 244, 1'b0, cls_white);
        add_row("lpad_left_out",   194, 260, 1'b0, cls_dim);
        add_row("lpad_right_edge", 214, 300, 1'b0, cls_white);
        add_row("lpad_right_out",  215, 300, 1'b0, cls_dim);
        add_row("rpad_right_edge", 763, 300, 1'b0, cls_white);
        add_row("rpad_right_out",  764, 300, 1'b0, cls_dim);
        add_row("lpad_below",      200, 324, 1'b0, cls_dim);
        add_row("background",      400, 400, 1'b0, cls_dim);
        add_row("last_pixel",      799, 524, 1'b0, cls_dim);
        add_row("ball_left_in",      0,   0, 1'b1, cls_white);
        add_row("ball_right_in",     9,   0, 1'b1, cls_white);
        add_row("ball_left_out",    -1,   0, 1'b1, cls_dim);
        add_row("ball_right_out",   10,   0, 1'b1, cls_dim);

        repeat (2) @(posedge iCLK);
        #drive_delay;
        iRST_N = 1'b1;

        for (int i = 0; i < row_name.size(); i++)
            run_row(i);

        // Play on until both players hold the top score
        n = 0;
        while (!((msl == 10) && (msr == 10))) begin
            @(posedge iCLK);
            #drive_delay;
            n++;
            if (n > ball_limit) begin
                $display("Timed out waiting for both scores to reach ten");
                stop_on_error();
            end
        end
        repeat (20000) begin                        // Several more wall hits
            @(negedge iCLK);
            check_score("score_hold", '{left: 4'd10, right: 4'd10}, score);
        end

        if (dut.u_assert.fails == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

/* test/pong_assert.sv */
`timescale 1ns/10ps

module pong_assert
    import pong_pkg::*;
(
    input logic        iCLK,
    input logic        iRST_N,
    input screen_pos_t pos,
    input vga_sync_t   sync,
    input rgb_t        pixel_out,
    input score_t      score
);

    int fails = 0;                                  // Read by the testbench at the end

    a_h_range: assert property (@(posedge iCLK) disable iff (!iRST_N)
        pos.h < 11'd800)
        else begin
            $error("Horizontal count past 799");
            fails++;
        end

    // Blanking must be black
    a_black: assert property (@(posedge iCLK) disable iff (!iRST_N)
        !sync.visible |-> (pixel_out == '0))
        else begin
            $error("Colour output during blanking");
            fails++;
        end

    a_score_max: assert property (@(posedge iCLK) disable iff (!iRST_N)
        (score.left <= 4'd10) && (score.right <= 4'd10))
        else begin
            $error("Score above ten");
            fails++;
        end

    a_score_step: assert property (@(posedge iCLK) disable iff (!iRST_N)
        ((score.left == $past(score.left)) || (score.left == $past(score.left) + 4'd1)) &&
        ((score.right == $past(score.right)) || (score.right == $past(score.right) + 4'd1)))
        else begin
            $error("Score jumped by more than one");
            fails++;
        end

endmodule

bind pong_top pong_assert u_assert (
    .iCLK      (iCLK),
    .iRST_N    (iRST_N),
    .pos       (pos),
    .sync      (sync),
    .pixel_out (pixel_out),
    .score     (score)
);

/* source/pong_top.sv */
`timescale 1ns/10ps

module pong_top
    import pong_pkg::*;
#(
    parameter int move_tick_bits = 17       // Ball speed prescaler width
) (
    input  logic        iCLK,
    input  logic        iRST_N,
    input  rgb_t        pixel_in,
    output logic        request,
    output rgb_t        pixel_out,
    output vga_sync_t   sync,
    output screen_pos_t pos,
    output score_t      score
);

    logic      move_tick;
    ball_pos_t ball;
    logic      dir_right;
    logic      dir_down;
    logic      step_x;
    logic      step_y;
    logic      hit_left;
    logic      hit_right;

    // ========================================================================
    // Raster side
    // ========================================================================
    video_timing u_video_timing (
        .iCLK     (iCLK),
        .iRST_N   (iRST_N),
        .pos      (pos),
        .sync     (sync),
        .request  (request)
    );

    pixel_mixer u_pixel_mixer (
        .pos       (pos),
        .sync      (sync),
        .ball      (ball),
        .pixel_in  (pixel_in),
        .pixel_out (pixel_out)
    );

    // ========================================================================
    // Game side
    // ========================================================================
    move_timer #(
        .move_tick_bits (move_tick_bits)
    ) u_move_timer (
        .iCLK      (iCLK),
        .iRST_N    (iRST_N),
        .move_tick (move_tick)
    );

    rally_fsm u_rally_fsm (
        .iCLK      (iCLK),
        .iRST_N    (iRST_N),
        .move_tick (move_tick),
        .ball      (ball),
        .dir_right (dir_right),
        .dir_down  (dir_down),
        .step_x    (step_x),
        .step_y    (step_y),
        .hit_left  (hit_left),
        .hit_right (hit_right)
    );

    ball_position u_ball_position (
        .iCLK      (iCLK),
        .iRST_N    (iRST_N),
        .dir_right (dir_right),
        .dir_down  (dir_down),
        .step_x    (step_x),
        .step_y    (step_y),
        .ball      (ball)
    );

    score_keeper u_score_keeper (
        .iCLK      (iCLK),
        .iRST_N    (iRST_N),
        .hit_left  (hit_left),
        .hit_right (hit_right),
        .score     (score)
    );

endmodule

/* source/pixel_mixer.sv */
`timescale 1ns/10ps

module pixel_mixer
    import pong_pkg::*;
(
    input  screen_pos_t pos,
    input  vga_sync_t   sync,
    input  ball_pos_t   ball,
    input  rgb_t        pixel_in,   // Background from the source
    output rgb_t        pixel_out
);

    localparam rgb_t white = '{r: 8'hFF, g: 8'hFF, b: 8'hFF};
    localparam rgb_t black = '{r: 8'h00, g: 8'h00, b: 8'h00};

    logic in_paddle_rows;
    logic in_left_paddle;
    logic in_right_paddle;
    logic in_ball;
    logic on_centre_line;
    rgb_t dimmed;

    // ========================================================================
    // Object hit tests
    // ========================================================================
    assign in_paddle_rows  = (pos.v >= paddle_y) && (pos.v < paddle_y + paddle_h);
    assign in_left_paddle  = in_paddle_rows &&
                             (pos.h >= paddle_left_x) && (pos.h < paddle_left_x + paddle_w);
    assign in_right_paddle = in_paddle_rows &&
                             (pos.h >= paddle_right_x) && (pos.h < paddle_right_x + paddle_w);

    // Ball square spans ball_size pixels from its corner
    assign in_ball = (pos.h >= ball.x) && (pos.h < ball.x + ball_size) &&
                     (pos.v >= ball.y) && (pos.v < ball.y + ball_size);

    // Dashes of 32 lines, gaps of 32
    assign on_centre_line = (pos.h == centre_line_x) && !pos.v[5];

    // Background at half intensity
    assign dimmed = '{r: pixel_in.r >> 1, g: pixel_in.g >> 1, b: pixel_in.b >> 1};

    // ========================================================================
    // Colour choice
    // ========================================================================
    always_comb begin
        if (!sync.visible)
            pixel_out = black;                  // Blanking
        else if (in_left_paddle || in_right_paddle || in_ball)
            pixel_out = white;
        else if (on_centre_line)
            pixel_out = white;
        else
            pixel_out = dimmed;
    end

endmodule

/* source/score_keeper.sv */
`timescale 1ns/10ps

module score_keeper
    import pong_pkg::*;
(
    input  logic   iCLK,
    input  logic   iRST_N,
    input  logic   hit_left,    // Point for the left player
    input  logic   hit_right,   // Point for the right player
    output score_t score
);

    score_t score_q;

    // Both counters stop at score_max
    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            score_q <= '0;
        end else begin
            if (hit_left && (score_q.left < score_max))
                score_q.left <= score_q.left + 4'd1;
            if (hit_right && (score_q.right < score_max))
                score_q.right <= score_q.right + 4'd1;
        end
    end

    assign score = score_q;

endmodule

/* source/ball_position.sv */
`timescale 1ns/10ps

module ball_position
    import pong_pkg::*;
(
    input  logic      iCLK,
    input  logic      iRST_N,
    input  logic      dir_right,
    input  logic      dir_down,
    input  logic      step_x,
    input  logic      step_y,
    output ball_pos_t ball          // Top-left corner
);

    logic [10:0] x_q;
    logic [9:0]  y_q;

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            x_q <= 11'(ball_x_init);            // Serve from screen centre
            y_q <= 10'(ball_y_init);
        end else begin
            if (step_x) begin
                if (dir_right)
                    x_q <= x_q + 11'd1;
                else
                    x_q <= x_q - 11'd1;
            end
            if (step_y) begin
                if (dir_down)
                    y_q <= y_q + 10'd1;         // Down is increasing v
                else
                    y_q <= y_q - 10'd1;
            end
        end
    end

    assign ball = '{x: x_q, y: y_q};

endmodule

/* source/rally_fsm.sv */
`timescale 1ns/10ps

module rally_fsm
    import pong_pkg::*;
(
    input  logic      iCLK,
    input  logic      iRST_N,
    input  logic      move_tick,
    input  ball_pos_t ball,
    output logic      dir_right,
    output logic      dir_down,
    output logic      step_x,       // Move x one pixel this tick
    output logic      step_y,
    output logic      hit_left,     // Right wall reached, point to left player
    output logic      hit_right     // Left wall reached, point to right player
);

    ball_dir_e state;
    ball_dir_e state_n;
    logic      next_right;
    logic      next_down;
    logic      at_right_wall;
    logic      at_left_wall;
    logic      at_bottom_wall;
    logic      at_top_wall;

    assign dir_right = (state == dir_up_right) || (state == dir_down_right);
    assign dir_down  = (state == dir_down_left) || (state == dir_down_right);

    // Wall tests against the ball corner
    assign at_right_wall  = (ball.x + ball_size >= ball_x_max);
    assign at_left_wall   = (ball.x <= ball_x_min);
    assign at_bottom_wall = (ball.y + ball_size >= ball_y_max);
    assign at_top_wall    = (ball.y <= ball_y_min);

    always_comb begin
        next_right = dir_right;
        next_down  = dir_down;
        step_x     = 1'b0;
        step_y     = 1'b0;
        hit_left   = 1'b0;
        hit_right  = 1'b0;
        if (move_tick) begin
            // Horizontal axis, a bounce replaces the step
            if (dir_right && at_right_wall) begin
                next_right = 1'b0;
                hit_left   = 1'b1;
            end else if (!dir_right && at_left_wall) begin
                next_right = 1'b1;
                hit_right  = 1'b1;
            end else begin
                step_x = 1'b1;
            end
            // Vertical axis, no score here
            if (dir_down && at_bottom_wall)
                next_down = 1'b0;
            else if (!dir_down && at_top_wall)
                next_down = 1'b1;
            else
                step_y = 1'b1;
        end
        state_n = ball_dir_e'({next_down, next_right});   // Matches enum bit layout
    end

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            state <= dir_down_right;
        end else begin
            state <= state_n;
        end
    end

endmodule

/* source/move_timer.sv */
`timescale 1ns/10ps

module move_timer #(
    parameter int move_tick_bits = 17     // Tick period is 2**move_tick_bits clocks
) (
    input  logic iCLK,
    input  logic iRST_N,
    output logic move_tick                  // One clock wide
);

    logic [move_tick_bits-1:0] prescale;

    // Free-running, wraps on its own
    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            prescale <= '0;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // Fires at count 0, so the first clock after reset moves the ball
    assign move_tick = (prescale == '0);

endmodule

/* source/video_timing.sv */
`timescale 1ns/10ps

module video_timing
    import pong_pkg::*;
(
    input  logic        iCLK,
    input  logic        iRST_N,
    output screen_pos_t pos,        // Current raster count
    output vga_sync_t   sync,
    output logic        request     // Pixel data wanted soon
);

    logic [10:0] h_cnt;
    logic [9:0]  v_cnt;

    // ========================================================================
    // Raster counters
    // ========================================================================

    // Horizontal count, one step per clock
    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            h_cnt <= '0;
        end else if (h_cnt == h_total - 1) begin
            h_cnt <= '0;                        // End of line
        end else begin
            h_cnt <= h_cnt + 11'd1;
        end
    end

    // Vertical count, steps while h sits at 0
    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            v_cnt <= '0;
        end else if (h_cnt == '0) begin
            if (v_cnt == v_total - 1)
                v_cnt <= '0;                    // End of frame
            else
                v_cnt <= v_cnt + 10'd1;
        end
    end

    assign pos = '{h: h_cnt, v: v_cnt};

    // ========================================================================
    // Decode from the counts
    // ========================================================================

    // Horizontal sync pulled early by h_mark1
    assign sync.h_sync = !((h_cnt > h_front - h_mark1) &&
                           (h_cnt <= h_sync_len + h_front - h_mark1));
    assign sync.v_sync = !((v_cnt > v_front) &&
                           (v_cnt <= v_sync_len + v_front));
    assign sync.visible = (h_cnt >= h_blank) && (v_cnt >= v_blank);

    // Request window runs ahead of the visible area
    assign request = (h_cnt >= h_sync_len + h_back + h_mark) &&
                     (h_cnt <  h_sync_len + h_back + h_active + h_mark) &&
                     (v_cnt >= v_sync_len + v_back + v_mark) &&
                     (v_cnt <  v_sync_len + v_back + v_active + v_mark);

endmodule

/* source/pong_pkg.sv */
package pong_pkg;

    // ========================================================================
    // Raster timing, 640x480 inside an 800 x 525 frame
    // ========================================================================
    localparam int h_total    = 800;    // Counts per line
    localparam int v_total    = 525;    // Lines per frame
    localparam int h_front    = 16;
    localparam int h_sync_len = 96;
    localparam int h_back     = 48;
    localparam int h_active   = 640;
    localparam int v_front    = 10;
    localparam int v_sync_len = 2;
    localparam int v_back     = 33;
    localparam int v_active   = 480;

    localparam int h_mark     = 17;     // Request window lead
    localparam int h_mark1    = 10;     // Horizontal sync shift
    localparam int v_mark     = 9;

    localparam int h_blank    = h_front + h_sync_len + h_back;  // 160
    localparam int v_blank    = v_front + v_sync_len + v_back;  // 45

    // ========================================================================
    // Playfield objects, all in raster coordinates
    // ========================================================================
    localparam int ball_size      = 10;
    localparam int ball_x_min     = 150;    // Left wall
    localparam int ball_x_max     = 790;    // Right wall
    localparam int ball_y_min     = 50;     // Top wall
    localparam int ball_y_max     = 525;    // Bottom wall
    localparam int ball_x_init    = 320;
    localparam int ball_y_init    = 240;

    localparam int paddle_w       = 20;
    localparam int paddle_h       = 80;
    localparam int paddle_y       = 244;    // Shared top edge of both paddles
    localparam int paddle_left_x  = 195;
    localparam int paddle_right_x = 744;
    localparam int centre_line_x  = 465;

    localparam int score_max      = 10;     // Scores hold here

    // Raster position, h in the upper bits
    typedef struct packed {
        logic [10:0] h;
        logic [9:0]  v;
    } screen_pos_t;

    // Top-left corner of the ball
    typedef struct packed {
        logic [10:0] x;
        logic [9:0]  y;
    } ball_pos_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Syncs active low, visible high inside the shown area
    typedef struct packed {
        logic h_sync;
        logic v_sync;
        logic visible;
    } vga_sync_t;

    typedef struct packed {
        logic [3:0] left;
        logic [3:0] right;
    } score_t;

    // Bit 1 is the vertical sense, bit 0 the horizontal one
    typedef enum logic [1:0] {
        dir_up_left    = 2'b00,
        dir_up_right   = 2'b01,
        dir_down_left  = 2'b10,
        dir_down_right = 2'b11
    } ball_dir_e;

endpackage
